/* project.f */
+incdir+testbench
rtl/phy_cfg_pkg.sv
rtl/train_types_pkg.sv
rtl/delay_tap_ctrl.sv
rtl/train_handshake.sv
rtl/bit_train.sv
rtl/phy_train_top.sv
testbench/tb_phy_train.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_phy_train
FILELIST := project.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_eye_model.svh */
`ifndef TB_EYE_MODEL_SVH
`define TB_EYE_MODEL_SVH

// edges start at tap 6, so even 2 taps of jitter leave four clean samples
// of the old bit in front of the transition
function automatic int edge_from_draw(input int r);
  return 6 + (r % 35);  // edges from tap 6 to tap 40
endfunction

// inside this window rise and fall are not stable from cycle to cycle
function automatic logic in_window(input tap_t tap, input int edge_tap, input int jitter);
  int t;
  t = int'(tap);
  return (t >= edge_tap - jitter) && (t < edge_tap + jitter);
endfunction

// {rise, fall} seen by the capture flops for one bit at its tap setting
function automatic logic [1:0] eye_sample(input tap_t tap, input int edge_tap, input int jitter,
                                          input logic no_edge, input logic [1:0] noise);
  int t;
  t = int'(tap);
  if (no_edge) begin
    return 2'b00;  // stuck line, the pattern never toggles
  end
  if (t < edge_tap - jitter) begin
    return 2'b01;  // still sampling the previous bit
  end
  if (t >= edge_tap + jitter) begin
    return 2'b10;
  end
  return noise;
endfunction

// a 2.5 ns data bit at 200 MHz spans 32 taps of 78 ps, the centre lies 16 past the edge
function automatic int centre_tap(input int edge_tap);
  return edge_tap + 16;
endfunction

`endif

/* testbench/tb_phy_train.sv */
`timescale 1ns/1ps

module tb_phy_train;
  import phy_cfg_pkg::*;

  localparam int data_width     = 18;
  localparam int clk_freq       = 200;
  localparam int timeout_cycles = data_width * 64 * 20 * 6 + 10000;

  logic                  clk;
  logic                  reset;
  logic                  train_req;
  logic                  train_ack;
  logic                  train_fail;
  logic [data_width-1:0] q_rise;
  logic [data_width-1:0] q_fall;
  logic [data_width-1:0] aligned;
  logic [data_width-1:0] dly_inc_dec_n;
  logic [data_width-1:0] dly_en;
  logic [data_width-1:0] dly_rst;
  tap_t [data_width-1:0] tap_value;

  int          edge_tap [data_width];
  int          jitter;
  int          no_edge_bit;  // -1 when every bit has an edge
  tap_t        tap_model [data_width];
  logic [31:0] setup_lfsr;
  logic [31:0] noise_lfsr;
  int          cycle_count;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;

  `include "tb_eye_model.svh"

  phy_train_top #(
    .data_width (data_width),
    .clk_freq   (clk_freq)
  ) dut_i (
    .clk           (clk),
    .reset         (reset),
    .train_req     (train_req),
    .train_ack     (train_ack),
    .train_fail    (train_fail),
    .q_rise        (q_rise),
    .q_fall        (q_fall),
    .aligned       (aligned),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_en        (dly_en),
    .dly_rst       (dly_rst),
    .tap_value     (tap_value)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int k = 0; k < n; k++) begin
      setup_lfsr = lfsr_next(setup_lfsr);
      value      = (value << 1) | int'(setup_lfsr[0]);
    end
  endtask

  // ----------------------------------------------------------------------
  // channel model that follows each bit's tap setting every cycle
  // ----------------------------------------------------------------------

  initial begin : channel
    logic [1:0] noise;
    logic [1:0] sample;
    noise_lfsr = 32'h5e9a_38c0;
    q_rise     = '0;
    q_fall     = '0;
    forever begin
      @(negedge clk);
      for (int i = 0; i < data_width; i++) begin
        noise = 2'b00;
        if (i != no_edge_bit && in_window(tap_value[i], edge_tap[i], jitter)) begin
          noise_lfsr = lfsr_next(noise_lfsr);
          noise[1]   = noise_lfsr[0];
          noise_lfsr = lfsr_next(noise_lfsr);
          noise[0]   = noise_lfsr[0];
        end
        sample    = eye_sample(tap_value[i], edge_tap[i], jitter, i == no_edge_bit, noise);
        q_rise[i] = sample[1];
        q_fall[i] = sample[0];
      end
    end
  end

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_vector(input string name, input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_tap(input string name, input tap_t got, input tap_t lo, input tap_t hi);
    if ($isunknown(got) || got < lo || got > hi) begin
      $display("ERR %s got 0x%0h expected 0x%0h..0x%0h", name, got, lo, hi);
      test_errors++;
    end
  endtask

  task automatic check_taps(input tap_t [data_width-1:0] taps, input int tol, input int skip_bit);
    tap_t lo;
    tap_t hi;
    for (int i = 0; i < data_width; i++) begin
      if (i != skip_bit) begin
        lo = tap_t'(centre_tap(edge_tap[i]) - tol);
        hi = tap_t'(centre_tap(edge_tap[i]) + tol);
        check_tap($sformatf("tap_value[%0d]", i), taps[i], lo, hi);
      end
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // ----------------------------------------------------------------------
  // tap mirror rebuilt from the commands sent to the delay lines
  // ----------------------------------------------------------------------

  // a line saturates at both ends and a reset of the line wins over a step
  always @(posedge clk) begin
    for (int i = 0; i < data_width; i++) begin
      if (reset || dly_rst[i]) begin
        tap_model[i] <= '0;
      end else if (dly_en[i] && dly_inc_dec_n[i] && tap_model[i] != max_tap) begin
        tap_model[i] <= tap_model[i] + 6'd1;
      end else if (dly_en[i] && !dly_inc_dec_n[i] && tap_model[i] != 6'd0) begin
        tap_model[i] <= tap_model[i] - 6'd1;
      end
    end
  end

  always @(negedge clk) begin
    for (int i = 0; i < data_width; i++) begin
      check_tap($sformatf("tap_value[%0d]", i), tap_value[i], tap_model[i], tap_model[i]);
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  // new edges are set just after a rising edge while the channel samples on the falling one
  task automatic setup_eyes(input int jit, input int dead_bit);
    int r;
    @(posedge clk);
    jitter      = jit;
    no_edge_bit = dead_bit;
    for (int i = 0; i < data_width; i++) begin
      draw_bits(6, r);
      edge_tap[i] = edge_from_draw(r);
    end
  endtask

  // one full four-phase exchange with the results taken while ack is high
  task automatic run_training(output logic fail_q, output logic [data_width-1:0] aligned_q,
                              output tap_t [data_width-1:0] taps_q);
    @(negedge clk) train_req = 1'b1;
    @(negedge clk) check_flag("train_ack", train_ack, 1'b0);  // run has only just begun
    while (train_ack !== 1'b1) @(negedge clk);
    fail_q    = train_fail;
    aligned_q = aligned;
    taps_q    = tap_value;
    repeat (3) @(negedge clk);  // results must not move while req is still held
    check_flag("train_ack", train_ack, 1'b1);
    check_flag("train_fail", train_fail, fail_q);
    check_vector("aligned", aligned, aligned_q);
    train_req = 1'b0;
    @(negedge clk) check_flag("train_ack", train_ack, 1'b0);
    repeat (4) @(negedge clk);  // lets the clear reach the trainer and the handshake go idle
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: training did not finish within %0d cycles", timeout_cycles);
    $display("Something failed");
    $finish;
  end

  initial begin : main_flow
    int                    r;
    int                    dead;
    logic                  res_fail;
    logic [data_width-1:0] res_aligned;
    logic [data_width-1:0] exp_aligned;
    tap_t [data_width-1:0] res_taps;
    reset        = 1'b1;
    train_req    = 1'b0;
    jitter       = 0;
    no_edge_bit  = -1;
    setup_lfsr   = 32'h5e9a_38c0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < data_width; i++) begin
      edge_tap[i] = 32;
    end
    repeat (8) @(posedge clk);
    @(negedge clk) reset = 1'b0;

    check_flag("train_ack", train_ack, 1'b0);
    check_flag("train_fail", train_fail, 1'b0);
    check_vector("aligned", aligned, '1);
    check_vector("dly_en", dly_en, '0);
    for (int i = 0; i < data_width; i++) begin
      check_tap($sformatf("tap_value[%0d]", i), tap_value[i], 6'd0, 6'd0);
    end
    finish_test("reset values");

    setup_eyes(0, -1);
    run_training(res_fail, res_aligned, res_taps);
    check_flag("train_fail", res_fail, 1'b0);
    check_vector("aligned", res_aligned, '1);
    check_taps(res_taps, 3, -1);
    finish_test("clean eyes");

    draw_bits(1, r);
    setup_eyes(1 + r, -1);  // one or two taps of jitter
    run_training(res_fail, res_aligned, res_taps);
    check_flag("train_fail", res_fail, 1'b0);
    check_vector("aligned", res_aligned, '1);
    check_taps(res_taps, 5, -1);
    finish_test("jittered eyes");

    draw_bits(5, r);
    dead = r % data_width;
    setup_eyes(0, dead);
    run_training(res_fail, res_aligned, res_taps);
    exp_aligned       = '1;
    exp_aligned[dead] = 1'b0;
    check_flag("train_fail", res_fail, 1'b1);
    check_vector("aligned", res_aligned, exp_aligned);
    check_tap($sformatf("tap_value[%0d]", dead), res_taps[dead], 6'd0, 6'd0);
    check_taps(res_taps, 3, dead);
    finish_test("bit without edge");

    // the failed run above must have been cleared by the release of req
    check_flag("train_fail", train_fail, 1'b0);
    check_vector("aligned", aligned, '1);
    setup_eyes(0, -1);
    run_training(res_fail, res_aligned, res_taps);
    check_flag("train_fail", res_fail, 1'b0);
    check_vector("aligned", res_aligned, '1);
    check_taps(res_taps, 3, -1);
    finish_test("handshake rerun");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* rtl/phy_train_top.sv */
`timescale 1ns/1ps

module phy_train_top #(
  parameter int data_width = 18,
  parameter int clk_freq   = 200
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                train_req,
  output logic                                train_ack,
  output logic                                train_fail,
  input  logic               [data_width-1:0] q_rise,
  input  logic               [data_width-1:0] q_fall,
  output logic               [data_width-1:0] aligned,
  output logic               [data_width-1:0] dly_inc_dec_n,
  output logic               [data_width-1:0] dly_en,
  output logic               [data_width-1:0] dly_rst,
  output phy_cfg_pkg::tap_t  [data_width-1:0] tap_value
);

  logic train_start;
  logic train_clear;
  logic train_done;

  train_handshake handshake_i (
    .clk         (clk),
    .reset       (reset),
    .train_req   (train_req),
    .train_done  (train_done),
    .train_ack   (train_ack),
    .train_start (train_start),
    .train_clear (train_clear)
  );

  bit_train #(
    .data_width (data_width),
    .clk_freq   (clk_freq)
  ) trainer_i (
    .clk           (clk),
    .reset         (reset),
    .train_start   (train_start),
    .train_clear   (train_clear),
    .train_done    (train_done),
    .train_fail    (train_fail),
    .q_rise        (q_rise),
    .q_fall        (q_fall),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_en        (dly_en),
    .dly_rst       (dly_rst),
    .aligned       (aligned)
  );

  // mirrors the settings sent to the external delay lines
  delay_tap_ctrl #(
    .data_width (data_width)
  ) taps_i (
    .clk           (clk),
    .reset         (reset),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_en        (dly_en),
    .dly_rst       (dly_rst),
    .tap_value     (tap_value)
  );

endmodule

/* rtl/bit_train.sv */
`timescale 1ns/1ps

module bit_train #(
  parameter int data_width = 18,
  parameter int clk_freq   = 200
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  train_start,
  input  logic                  train_clear,
  output logic                  train_done,
  output logic                  train_fail,
  input  logic [data_width-1:0] q_rise,
  input  logic [data_width-1:0] q_fall,
  output logic [data_width-1:0] dly_inc_dec_n,
  output logic [data_width-1:0] dly_en,
  output logic [data_width-1:0] dly_rst,
  output logic [data_width-1:0] aligned
);
  import phy_cfg_pkg::*;
  import train_types_pkg::*;

  localparam tap_t       half_steps = half_bit_steps(clk_freq);
  localparam logic [4:0] last_bit   = 5'(data_width - 1);

  function automatic logic valid(input logic [1:0] s);
    return s[1] ^ s[0];  // a training sample is only usable when rise and fall differ
  endfunction

  train_state_e state;
  acq_mode_e    mode;

  logic [1:0] curr_reg;  // {rise, fall} of the selected bit, one cycle old
  logic [1:0] curr;      // last acquired value, 2'b00 when rejected
  logic [1:0] prev;      // last value that was valid and stable
  logic [1:0] hist0;
  logic [1:0] hist1;
  logic [1:0] hist2;

  logic [5:0] acq_cnt;
  tap_t       progress;  // taps stepped in search, taps left in back/forward
  tap_t       baddies;   // unstable steps seen around the edge
  logic [4:0] bit_index;

  logic       history_stable;
  logic [6:0] corr;
  logic [6:0] fwd_steps;
  logic [6:0] back_steps;
  logic       fwd_fits;

  assign history_stable = (curr == hist0) && (hist0 == hist1) && (hist1 == hist2);

  // ----------------------------------------------------------------------
  // centering offsets from the point where the edge was confirmed
  // ----------------------------------------------------------------------

  // the edge sits about two taps plus half the unstable run behind the current tap
  assign corr       = 7'(baddies >> 1) + 7'd2;
  assign fwd_steps  = (7'(half_steps) > corr) ? 7'(half_steps) - corr : 7'd0;
  assign back_steps = 7'(half_steps) + corr;
  assign fwd_fits   = (7'(progress) + fwd_steps) <= 7'(max_tap);  // prefer the later eye

  always_ff @(posedge clk) begin
    dly_en   <= '0;  // delay commands are single-cycle pulses
    dly_rst  <= '0;
    curr_reg <= {q_rise[bit_index], q_fall[bit_index]};

    if (reset) begin
      state         <= st_idle;
      mode          <= mode_default;
      train_done    <= 1'b0;
      train_fail    <= 1'b0;
      aligned       <= '1;
      dly_inc_dec_n <= '0;
      dly_rst       <= '1;  // all lines back to tap 0
      curr          <= 2'b00;
      prev          <= 2'b00;
      hist0         <= 2'b00;
      hist1         <= 2'b00;
      hist2         <= 2'b00;
      acq_cnt       <= '0;
      progress      <= '0;
      baddies       <= '0;
      bit_index     <= '0;
    end else if (train_clear) begin
      state      <= st_idle;
      mode       <= mode_default;
      train_done <= 1'b0;
      train_fail <= 1'b0;
      aligned    <= '1;
      bit_index  <= '0;
    end else begin
      case (mode)
        mode_default: begin
          case (state)
            st_idle: begin
              if (train_start) begin
                state    <= st_search;
                mode     <= mode_acquire;
                dly_rst  <= '1;  // every run starts searching from tap 0
                acq_cnt  <= '0;
                progress <= '0;
                baddies  <= '0;
                prev     <= 2'b00;
                hist0    <= 2'b00;
                hist1    <= 2'b00;
                hist2    <= 2'b00;
              end
            end

            st_search: begin
              hist0 <= curr;
              hist1 <= hist0;
              hist2 <= hist1;
              if (curr != prev && valid(curr) && valid(prev) && history_stable) begin
                // edge confirmed, now move half a bit towards the eye centre
                if (fwd_fits) begin
                  state    <= st_forward;
                  progress <= fwd_steps[5:0];
                end else begin
                  state    <= st_back;
                  progress <= back_steps[5:0];
                end
              end else if (progress == max_tap) begin
                // whole line swept without a transition
                state               <= st_align;
                progress            <= 6'd4;
                train_fail          <= 1'b1;
                dly_rst[bit_index]  <= 1'b1;
              end else begin
                mode                     <= mode_acquire;
                acq_cnt                  <= '0;
                progress                 <= progress + 6'd1;
                dly_inc_dec_n[bit_index] <= 1'b1;
                dly_en[bit_index]        <= 1'b1;
                if (valid(curr) && history_stable) begin
                  prev <= curr;
                end
                // once the edge region starts every further step counts
                if (baddies != '0 || (valid(prev) && curr != prev)) begin
                  baddies <= baddies + 6'd1;
                end
              end
            end

            st_back,
            st_forward: begin
              hist0 <= curr;
              hist1 <= hist0;
              hist2 <= hist1;
              if (progress != '0) begin
                mode                     <= mode_acquire;
                acq_cnt                  <= '0;
                progress                 <= progress - 6'd1;
                dly_inc_dec_n[bit_index] <= (state == st_forward);
                dly_en[bit_index]        <= 1'b1;
              end else begin
                state    <= st_align;
                progress <= 6'd4;
                if (!valid(curr) || !history_stable) begin
                  train_fail <= 1'b1;  // the centre of the eye is not clean
                end
              end
            end

            st_align: begin
              if (progress != '0) begin
                progress <= progress - 6'd1;  // let the last step settle
              end else begin
                state <= st_done;
                if (!curr_reg[1]) begin
                  aligned[bit_index] <= 1'b0;
                end
              end
            end

            st_done: begin
              if (bit_index < last_bit) begin
                state     <= st_search;
                mode      <= mode_acquire;
                acq_cnt   <= '0;
                progress  <= '0;
                baddies   <= '0;
                prev      <= 2'b00;
                hist0     <= 2'b00;
                hist1     <= 2'b00;
                hist2     <= 2'b00;
                bit_index <= bit_index + 5'd1;
              end else begin
                train_done <= 1'b1;  // held until the handshake clears it
              end
            end

            default: state <= st_idle;
          endcase
        end

        mode_acquire: begin
          acq_cnt <= acq_cnt + 6'd1;
          // the first two samples still show the line before the tap update
          if (acq_cnt >= 6'd2) begin
            if (!valid(curr_reg) || (acq_cnt > 6'd2 && curr_reg != curr)) begin
              mode <= mode_default;
              curr <= 2'b00;
            end else begin
              curr <= curr_reg;
              if (acq_cnt >= acquire_threshold) begin
                mode <= mode_default;
              end
            end
          end
        end

        default: mode <= mode_default;
      endcase
    end
  end

  // only the selected bit's delay line may be stepped
  assert property (@(posedge clk) disable iff (reset) $onehot0(dly_en));

  // a new run is launched only after the handshake cleared the last result
  assert property (@(posedge clk) disable iff (reset) !(train_done && train_start));

endmodule

/* rtl/train_handshake.sv */
`timescale 1ns/1ps

module train_handshake (
  input  logic clk,
  input  logic reset,
  input  logic train_req,
  input  logic train_done,
  output logic train_ack,
  output logic train_start,
  output logic train_clear
);
  import train_types_pkg::*;

  hs_phase_e phase;

  always_ff @(posedge clk) begin
    train_start <= 1'b0;
    train_clear <= 1'b0;

    if (reset) begin
      phase     <= hs_wait_req;
      train_ack <= 1'b0;
    end else begin
      case (phase)
        hs_wait_req: begin
          if (train_req) begin
            phase       <= hs_running;
            train_start <= 1'b1;
          end
        end
        hs_running: begin
          if (train_done) begin
            phase     <= hs_ack_high;
            train_ack <= 1'b1;  // results stay frozen while req is held
          end
        end
        hs_ack_high: begin
          if (!train_req) begin
            phase       <= hs_wait_release;
            train_ack   <= 1'b0;
            train_clear <= 1'b1;
          end
        end
        hs_wait_release: begin
          if (!train_done) phase <= hs_wait_req;  // trainer has taken the clear
        end
        default: phase <= hs_wait_req;
      endcase
    end
  end

  // the host holds req until it sees ack
  assert property (@(posedge clk) disable iff (reset) $rose(train_ack) |-> train_req);

endmodule

/* rtl/delay_tap_ctrl.sv */
`timescale 1ns/1ps

module delay_tap_ctrl #(
  parameter int data_width = 18
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic               [data_width-1:0]  dly_inc_dec_n,
  input  logic               [data_width-1:0]  dly_en,
  input  logic               [data_width-1:0]  dly_rst,
  output phy_cfg_pkg::tap_t  [data_width-1:0]  tap_value
);
  import phy_cfg_pkg::*;
  import train_types_pkg::*;

  for (genvar i = 0; i < data_width; i++) begin : g_tap
    tap_cmd_e cmd;
    tap_t     tap_q;

    // reset of a line wins over a step in the same cycle
    always_comb begin
      if (dly_rst[i]) begin
        cmd = tap_rst;
      end else if (dly_en[i]) begin
        cmd = dly_inc_dec_n[i] ? tap_inc : tap_dec;
      end else begin
        cmd = tap_hold;
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        tap_q <= '0;
      end else begin
        case (cmd)
          tap_inc: if (tap_q != max_tap) tap_q <= tap_q + 6'd1;  // line stops at its end
          tap_dec: if (tap_q != '0) tap_q <= tap_q - 6'd1;
          tap_rst: tap_q <= '0;
          default: tap_q <= tap_q;
        endcase
      end
    end

    assign tap_value[i] = tap_q;

    // the trainer must never push a line past its last tap
    assert property (@(posedge clk) disable iff (reset) (cmd == tap_inc) |-> (tap_q != max_tap));
  end

endmodule

/* rtl/train_types_pkg.sv */
package train_types_pkg;

  // per-bit training sequence
  typedef enum logic [2:0] {
    st_idle,
    st_search,
    st_back,
    st_forward,
    st_align,
    st_done
  } train_state_e;

  // whether the trainer is deciding or still sampling the line
  typedef enum logic {
    mode_default,
    mode_acquire
  } acq_mode_e;

  // phases of the four-phase req/ack exchange with the host
  typedef enum logic [1:0] {
    hs_wait_req,
    hs_running,
    hs_ack_high,
    hs_wait_release
  } hs_phase_e;

  // command seen by one delay line in a cycle
  typedef enum logic [1:0] {
    tap_hold,
    tap_inc,
    tap_dec,
    tap_rst
  } tap_cmd_e;

endpackage

/* rtl/phy_cfg_pkg.sv */
package phy_cfg_pkg;

  // ----------------------------------------------------------------------
  // delay line
  // ----------------------------------------------------------------------

  localparam logic [31:0] dly_delta_ps = 32'd78;  // one tap with a 200 MHz reference

  localparam logic [5:0] max_tap = 6'd63;  // last tap of the 64-tap line

  typedef logic [5:0] tap_t;  // tap setting or step count

  // ----------------------------------------------------------------------
  // trainer timing
  // ----------------------------------------------------------------------

  // stable samples needed before an acquisition counts as done
  localparam logic [5:0] acquire_threshold = 6'd16;

  // one DDR bit lasts half a clock period, so 500000 / f_MHz gives its width in ps
  function automatic tap_t half_bit_steps(input int unsigned freq_mhz);
    int unsigned bit_ps;
    int unsigned bit_taps;
    bit_ps   = 500000 / freq_mhz;
    bit_taps = bit_ps / dly_delta_ps;
    return tap_t'(bit_taps / 2);  // 2500 ps / 78 ps gives 32 taps, half of that at 200 MHz
  endfunction

endpackage
